/* Makefile */
# Verilator simulation of the RV32I execute subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module rv_exec_tb -f rv_exec_top.f
	@out=$$(./obj_dir/Vrv_exec_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

/* bench/rv_exec_patterns.txt */
// instr    rd  data      illegal  burst
// burst 1 means no idle gap before the line and output ready held high
00500093 01 00000005 0 0
FFD00113 02 FFFFFFFD 0 0
123451B7 03 12345000 0 0
6781E193 03 12345678 0 1
FFF1C213 04 EDCBA987 0 1
0F027293 05 00000080 0 1
00208333 06 00000002 0 0
402083B3 07 00000008 0 1
00621433 08 B72EA61C 0 0
006154B3 09 3FFFFFFF 0 0
40615533 0A FFFFFFFF 0 0
001125B3 0B 00000001 0 0
00113633 0C 00000000 0 0
00708013 00 0000000C 0 0
001006B3 0D 00000005 0 1
40115713 0E FFFFFFFE 0 0
00425793 0F 0EDCBA98 0 0
01F09813 10 80000000 0 0
FFE12893 11 00000001 0 0
FFF0B913 12 00000001 0 0
022080B3 00 00000000 1 0
4020C0B3 00 00000000 1 0
40109093 00 00000000 1 0
00002083 00 00000000 1 0
00001097 00 00000000 1 0
00008993 13 00000005 0 1
0051EA33 14 123456F8 0 0
00827AB3 15 A50AA004 0 0

/* bench/rv_exec_properties.sv */
`timescale 1ns/1ns

module rv_exec_properties
(
    input logic                   i_clk,
    input logic                   i_rst_n,
    input logic                   i_instr_valid,
    input logic                   i_instr_ready,
    input logic                   i_wb_valid,
    input rv_exec_pkg::reg_addr_t i_wb_rd,
    input rv_exec_pkg::word_t     i_wb_data,
    input logic                   i_wb_illegal,
    input logic                   i_wb_ready
);

    // Record leaves, nothing new enters
    logic drain_only;

    assign drain_only = i_wb_valid && i_wb_ready && !(i_instr_valid && i_instr_ready);

    ////////////////////////////////////////
    // Handshake rules
    ////////////////////////////////////////

    // Execute stage empty once reset is seen
    reset_clears_wb: assert property (@(posedge i_clk) !i_rst_n |=> !i_wb_valid)
        else $error("o_wb_valid high after a reset cycle");

    // Stalled record held as is
    wb_stable_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_valid && !i_wb_ready) |=>
        (i_wb_valid && $stable(i_wb_rd) && $stable(i_wb_data) && $stable(i_wb_illegal)))
        else $error("Writeback record changed while stalled");

    // Illegal record names x0
    illegal_rd_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_valid && i_wb_illegal) |-> (i_wb_rd == '0))
        else $error("Illegal record with nonzero rd");

    // No second record without a second instruction
    one_record_each: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        drain_only |=> !i_wb_valid)
        else $error("Record repeated without an accepted instruction");

endmodule

/* bench/rv_exec_tb.sv */
`timescale 1ns/1ns

module rv_exec_tb;

    import rv_exec_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_PAT = 40;
    localparam int MAX_PATTERNS   = 64;
    // Columns of one pattern line
    localparam int NUM_COLS       = 5;
    localparam int COL_INSTR      = 0;
    localparam int COL_RD         = 1;
    localparam int COL_DATA       = 2;
    localparam int COL_ILLEGAL    = 3;
    localparam int COL_BURST      = 4;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    logic      instr_ready;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      wb_illegal;
    logic      wb_ready;

    // Pattern words with five per line
    word_t pat_mem [0:MAX_PATTERNS*NUM_COLS-1];
    int    num_patterns = 0;
    int    num_checked  = 0;
    int    num_errors   = 0;
    logic  loaded       = 1'b0;

    // Expected fill of the execute stage
    logic  exp_busy;

    tb_clock_gen tb_clock_gen_i
    (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    rv_exec_top rv_exec_top_i
    (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .o_instr_ready (instr_ready),
        .i_instr       (instr),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data),
        .o_wb_illegal  (wb_illegal),
        .i_wb_ready    (wb_ready)
    );

    bind rv_exec_top rv_exec_properties rv_exec_properties_i
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr_ready (o_instr_ready),
        .i_wb_valid    (o_wb_valid),
        .i_wb_rd       (o_wb_rd),
        .i_wb_data     (o_wb_data),
        .i_wb_illegal  (o_wb_illegal),
        .i_wb_ready    (i_wb_ready)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic word_t pattern_word(input int line, input int col);
        return pat_mem[line*NUM_COLS+col];
    endfunction

    // Output ready about three cycles in four
    function automatic logic random_ready();
        return ($urandom_range(3, 0) != 0);
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
            num_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial
    begin
        logic burst;
        int   gap;
        instr_valid = 1'b0;
        instr       = '0;
        wb_ready    = 1'b0;
        void'($urandom(60));
        // Fill first so the end of the file shows up
        for (int k = 0; k < MAX_PATTERNS*NUM_COLS; k++)
        begin
            pat_mem[k] = 32'hA5A5_0000 ^ k;
        end
        $readmemh("bench/rv_exec_patterns.txt", pat_mem);
        // Valid lines have 0 or 1 in the illegal column
        while ((num_patterns < MAX_PATTERNS) &&
               (pattern_word(num_patterns, COL_ILLEGAL) <= 32'd1))
        begin
            num_patterns++;
        end
        if (num_patterns == 0)
        begin
            $display("No pattern lines could be read from the pattern file");
            num_errors++;
        end
        loaded = 1'b1;

        wait (rst_n == 1'b1);
        @(posedge clk);

        for (int p = 0; p < num_patterns; p++)
        begin
            burst = (pattern_word(p, COL_BURST) != '0);
            gap   = burst ? 0 : $urandom_range(3, 0);
            // Idle cycles before the instruction
            repeat (gap)
            begin
                instr_valid <= 1'b0;
                wb_ready    <= random_ready();
                @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr       <= pattern_word(p, COL_INSTR);
            // Burst lines keep the output moving for forwarding
            wb_ready    <= burst ? 1'b1 : random_ready();
            @(posedge clk);
            while (!instr_ready)
            begin
                wb_ready <= burst ? 1'b1 : random_ready();
                @(posedge clk);
            end
        end

        // Drain what is left
        instr_valid <= 1'b0;
        while (num_checked < num_patterns)
        begin
            wb_ready <= random_ready();
            @(posedge clk);
        end
        // A few more cycles to catch stray records
        wb_ready <= 1'b1;
        repeat (5) @(posedge clk);

        $display("Checked %0d of %0d patterns, %0d errors",
                 num_checked, num_patterns, num_errors);
        if ((num_errors == 0) && (num_checked == num_patterns))
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Record checker
    ////////////////////////////////////////

    // Records compared in order of transfer
    always @(posedge clk)
    begin
        logic exp_ready;
        // Stage empty or draining this cycle
        exp_ready = !exp_busy || wb_ready;
        if (!rst_n)
        begin
            exp_busy <= 1'b0;
        end
        else
        begin
            check_value("o_instr_ready", word_t'(instr_ready), word_t'(exp_ready));
            // Record shows in the cycle after acceptance
            check_value("o_wb_valid", word_t'(wb_valid), word_t'(exp_busy));
            exp_busy <= (instr_valid && exp_ready) || (exp_busy && !wb_ready);
            if (wb_valid && wb_ready)
            begin
                if (num_checked < num_patterns)
                begin
                    check_value("o_wb_rd", word_t'(wb_rd),
                                pattern_word(num_checked, COL_RD));
                    check_value("o_wb_data", wb_data, pattern_word(num_checked, COL_DATA));
                    check_value("o_wb_illegal", word_t'(wb_illegal),
                                pattern_word(num_checked, COL_ILLEGAL));
                    num_checked <= num_checked + 1;
                end
                else
                begin
                    $display("Extra writeback record at %0t with no pattern line left", $time);
                    num_errors++;
                end
            end
        end
    end

    // Time limit from the pattern count
    initial
    begin
        wait (loaded);
        #((num_patterns * CYCLES_PER_PAT + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout after %0t, only %0d of %0d patterns checked",
                 $time, num_checked, num_patterns);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen
(
    output logic o_clk,
    output logic o_rst_n
);

    // 100 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    // Reset low for ten rising edges
    initial
    begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ns
`include "rv_exec_cfg.svh"

module rv_alu
(
    input  rv_exec_pkg::alu_op_t i_op,
    input  rv_exec_pkg::word_t   i_a,
    input  rv_exec_pkg::word_t   i_b,
    output rv_exec_pkg::word_t   o_result
);

    import rv_exec_pkg::*;

    // Shift amount, low five bits of b
    logic [4:0] shamt;
    // Comparison flags
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////

    always_comb
    begin
        case (i_op)
            ALU_ADD:
                o_result = i_a + i_b;
            ALU_SUB:
                o_result = i_a - i_b;
            ALU_SLL:
                o_result = i_a << shamt;
            // Set-less-than gives 0 or 1
            ALU_SLT:
                o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:
                o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:
                o_result = i_a ^ i_b;
            ALU_SRL:
                o_result = i_a >> shamt;
            // Sign bit copied in from the left
            ALU_SRA:
                o_result = word_t'($signed(i_a) >>> shamt);
            ALU_OR:
                o_result = i_a | i_b;
            ALU_AND:
                o_result = i_a & i_b;
            ALU_PASSB:
                o_result = i_b;
            // Unused codes
            default:
                o_result = '0;
        endcase
    end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ns
`include "rv_exec_cfg.svh"

module rv_decoder
(
    input  rv_exec_pkg::word_t     i_instr,
    output rv_exec_pkg::reg_addr_t o_rs1_addr,
    output rv_exec_pkg::reg_addr_t o_rs2_addr,
    output rv_exec_pkg::reg_addr_t o_rd_addr,
    output rv_exec_pkg::word_t     o_imm,
    output logic                  o_use_imm,
    output rv_exec_pkg::alu_op_t   o_alu_op,
    output logic                  o_illegal
);

    import rv_exec_pkg::*;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // funct7 classes
    logic f7_base;
    logic f7_alt;
    // funct3 codes that allow the alternate funct7
    logic f3_has_alt;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign f7_base    = (funct7 == F7_BASE);
    assign f7_alt     = (funct7 == F7_ALT);
    assign f3_has_alt = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);

    ////////////////////////////////////////
    // Field and operation decode
    ////////////////////////////////////////

    always_comb
    begin
        // Fixed field positions for R, I and U types
        o_rs1_addr = i_instr[19:15];
        o_rs2_addr = i_instr[24:20];
        o_rd_addr  = i_instr[11:7];
        // I-type immediate, sign extended
        o_imm      = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
        o_use_imm  = 1'b0;
        o_alu_op   = ALU_ADD;
        o_illegal  = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                case (funct3)
                    F3_ADD_SUB: o_alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     o_alu_op = ALU_SLL;
                    F3_SLT:     o_alu_op = ALU_SLT;
                    F3_SLTU:    o_alu_op = ALU_SLTU;
                    F3_XOR:     o_alu_op = ALU_XOR;
                    F3_SRL_SRA: o_alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      o_alu_op = ALU_OR;
                    F3_AND:     o_alu_op = ALU_AND;
                endcase
                // Only SUB and SRA take the alternate funct7
                if (!(f7_base || (f7_alt && f3_has_alt)))
                begin
                    o_illegal = 1'b1;
                end
            end

            OPC_OPIMM:
            begin
                o_use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: o_alu_op = ALU_ADD;
                    F3_SLL:     o_alu_op = ALU_SLL;
                    F3_SLT:     o_alu_op = ALU_SLT;
                    F3_SLTU:    o_alu_op = ALU_SLTU;
                    F3_XOR:     o_alu_op = ALU_XOR;
                    F3_SRL_SRA: o_alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      o_alu_op = ALU_OR;
                    F3_AND:     o_alu_op = ALU_AND;
                endcase
                // Shift immediates carry funct7 in the upper bits
                if ((funct3 == F3_SLL) && !f7_base)
                begin
                    o_illegal = 1'b1;
                end
                if ((funct3 == F3_SRL_SRA) && !(f7_base || f7_alt))
                begin
                    o_illegal = 1'b1;
                end
            end

            OPC_LUI:
            begin
                // x0 as source, result is the U immediate
                o_rs1_addr = '0;
                o_imm      = {i_instr[31:12], 12'b0};
                o_use_imm  = 1'b1;
                o_alu_op   = ALU_PASSB;
            end

            default:
            begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

/* design/rv_exec_cfg.svh */
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

////////////////////////////////////////
// RV32I widths
////////////////////////////////////////

// Data and instruction word width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Bits needed to index one register
`define RV_RADDR_W 5

`endif

/* design/rv_exec_pkg.sv */
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    ////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////

    // Data or instruction word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index
    typedef logic [`RV_RADDR_W-1:0] reg_addr_t;

    // ALU operation code
    typedef logic [3:0] alu_op_t;

    // ALU operations
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    // Second operand straight through, for LUI
    localparam alu_op_t ALU_PASSB = 4'd10;

    ////////////////////////////////////////
    // Encoding fields
    ////////////////////////////////////////

    // Major opcodes
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;

    // funct3 values, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    // SUB, SRA and SRAI
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* design/rv_exec_top.sv */
`timescale 1ns/1ns

module rv_exec_top
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    output logic                   o_instr_ready,
    input  rv_exec_pkg::word_t     i_instr,
    output logic                   o_wb_valid,
    output rv_exec_pkg::reg_addr_t o_wb_rd,
    output rv_exec_pkg::word_t     o_wb_data,
    output logic                   o_wb_illegal,
    input  logic                   i_wb_ready
);

    import rv_exec_pkg::*;

    // Decode outputs
    reg_addr_t dec_rs1_addr;
    reg_addr_t dec_rs2_addr;
    reg_addr_t dec_rd_addr;
    word_t     dec_imm;
    logic      dec_use_imm;
    alu_op_t   dec_alu_op;
    logic      dec_illegal;

    // Register read data
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;

    // Execute stage to ALU
    word_t     alu_a;
    word_t     alu_b;
    alu_op_t   alu_op;
    word_t     alu_result;

    // Writeback into the register file
    reg_addr_t rf_addr;
    word_t     rf_data;
    logic      rf_we;

    ////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////

    rv_decoder rv_decoder_i
    (
        .i_instr    (i_instr),
        .o_rs1_addr (dec_rs1_addr),
        .o_rs2_addr (dec_rs2_addr),
        .o_rd_addr  (dec_rd_addr),
        .o_imm      (dec_imm),
        .o_use_imm  (dec_use_imm),
        .o_alu_op   (dec_alu_op),
        .o_illegal  (dec_illegal)
    );

    rv_regfile rv_regfile_i
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (dec_rs1_addr),
        .i_rs2_addr (dec_rs2_addr),
        .i_rd_addr  (rf_addr),
        .i_rd_data  (rf_data),
        .i_write_en (rf_we),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    ////////////////////////////////////////
    // Execute and writeback
    ////////////////////////////////////////

    rv_pipe_ctrl rv_pipe_ctrl_i
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_rd_addr     (dec_rd_addr),
        .i_rs1_data    (rf_rs1_data),
        .i_rs2_data    (rf_rs2_data),
        .i_imm         (dec_imm),
        .i_use_imm     (dec_use_imm),
        .i_alu_op      (dec_alu_op),
        .i_illegal     (dec_illegal),
        .o_alu_a       (alu_a),
        .o_alu_b       (alu_b),
        .o_alu_op      (alu_op),
        .i_alu_result  (alu_result),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_wb_illegal  (o_wb_illegal),
        .i_wb_ready    (i_wb_ready),
        .o_rf_addr     (rf_addr),
        .o_rf_data     (rf_data),
        .o_rf_we       (rf_we)
    );

    rv_alu rv_alu_i
    (
        .i_op     (alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

endmodule

/* design/rv_pipe_ctrl.sv */
`timescale 1ns/1ns

module rv_pipe_ctrl
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // Instruction handshake
    input  logic                   i_instr_valid,
    output logic                   o_instr_ready,
    // Decode stage
    input  rv_exec_pkg::reg_addr_t i_rd_addr,
    input  rv_exec_pkg::word_t     i_rs1_data,
    input  rv_exec_pkg::word_t     i_rs2_data,
    input  rv_exec_pkg::word_t     i_imm,
    input  logic                   i_use_imm,
    input  rv_exec_pkg::alu_op_t   i_alu_op,
    input  logic                   i_illegal,
    // ALU
    output rv_exec_pkg::word_t     o_alu_a,
    output rv_exec_pkg::word_t     o_alu_b,
    output rv_exec_pkg::alu_op_t   o_alu_op,
    input  rv_exec_pkg::word_t     i_alu_result,
    // Writeback record
    output logic                   o_wb_valid,
    output rv_exec_pkg::reg_addr_t o_wb_rd,
    output rv_exec_pkg::word_t     o_wb_data,
    output logic                   o_wb_illegal,
    input  logic                   i_wb_ready,
    // Register file write
    output rv_exec_pkg::reg_addr_t o_rf_addr,
    output rv_exec_pkg::word_t     o_rf_data,
    output logic                   o_rf_we
);

    import rv_exec_pkg::*;

    // Execute stage
    logic      ex_valid_q;
    word_t     ex_a_q;
    word_t     ex_b_q;
    alu_op_t   ex_op_q;
    reg_addr_t ex_rd_q;
    logic      ex_illegal_q;

    // Transfers this cycle
    logic      instr_fire;
    logic      wb_fire;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////

    assign wb_fire       = ex_valid_q && i_wb_ready;
    // Stage empty or draining this cycle
    assign o_instr_ready = !ex_valid_q || i_wb_ready;
    assign instr_fire    = i_instr_valid && o_instr_ready;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            ex_valid_q <= 1'b0;
        end
        else if (o_instr_ready)
        begin
            ex_valid_q <= i_instr_valid;
        end
    end

    // Operand capture on acceptance
    always_ff @(posedge i_clk)
    begin
        if (instr_fire)
        begin
            ex_a_q       <= i_rs1_data;
            ex_b_q       <= i_use_imm ? i_imm : i_rs2_data;
            ex_op_q      <= i_alu_op;
            // Illegal record reports x0
            ex_rd_q      <= i_illegal ? '0 : i_rd_addr;
            ex_illegal_q <= i_illegal;
        end
    end

    ////////////////////////////////////////
    // ALU and record
    ////////////////////////////////////////

    assign o_alu_a      = ex_a_q;
    assign o_alu_b      = ex_b_q;
    assign o_alu_op     = ex_op_q;

    assign o_wb_valid   = ex_valid_q;
    assign o_wb_rd      = ex_rd_q;
    // Illegal result forced to zero
    assign o_wb_data    = ex_illegal_q ? '0 : i_alu_result;
    assign o_wb_illegal = ex_illegal_q;

    // Register write only when the record leaves
    assign o_rf_addr    = ex_rd_q;
    assign o_rf_data    = o_wb_data;
    assign o_rf_we      = wb_fire && !ex_illegal_q;

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_exec_cfg.svh"

module rv_regfile
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  rv_exec_pkg::reg_addr_t i_rs1_addr,
    input  rv_exec_pkg::reg_addr_t i_rs2_addr,
    input  rv_exec_pkg::reg_addr_t i_rd_addr,
    input  rv_exec_pkg::word_t     i_rd_data,
    input  logic                  i_write_en,
    output rv_exec_pkg::word_t     o_rs1_data,
    output rv_exec_pkg::word_t     o_rs2_data
);

    import rv_exec_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs_q [1:`RV_NREGS-1];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < `RV_NREGS; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        // Writes to x0 dropped here
        else if (i_write_en && (i_rd_addr != '0))
        begin
            regs_q[i_rd_addr] <= i_rd_data;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // One read port, x0 first, then bypass, then array
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0)
        begin
            data = '0;
        end
        // Same-cycle write seen by the reader
        else if (i_write_en && (addr == i_rd_addr))
        begin
            data = i_rd_data;
        end
        else
        begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    assign o_rs1_data = read_port(i_rs1_addr);
    assign o_rs2_data = read_port(i_rs2_addr);

endmodule

/* rv_exec_top.f */
+incdir+design
design/rv_exec_pkg.sv
design/rv_regfile.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_pipe_ctrl.sv
design/rv_exec_top.sv
bench/tb_clock_gen.sv
bench/rv_exec_properties.sv
bench/rv_exec_tb.sv
